//--- src.f
+incdir+src
src/socPkg.sv
src/addrDecode.sv
src/dataRam.sv
src/ioBlock.sv
src/videoUnit.sv
src/socTop.sv
verif/socTb.sv

//--- run.sh
#!/bin/sh
# Build and run the SoC testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module socTb -f src.f > sim.log 2>&1 &&
./obj_dir/VsocTb >> sim.log 2>&1 ||
echo "Regression failed: build or simulation error" >> sim.log
cat sim.log
! grep -q "Regression failed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verif/socTb.sv
`default_nettype none

`include "soc_defs.svh"

module socTb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int FRAME = `H_TOTAL * `V_TOTAL;     // 384 clocks
    localparam int BLANK_VIS = `V_ACTIVE * `H_TOTAL - 1;  // Flag leads the sync view by one

    logic clk;
    logic rstN;
    socPkg::addrT addr;
    socPkg::byteT wData;
    logic wrEn;
    logic rdEn;
    socPkg::byteT rData;
    socPkg::byteT ioPins;
    logic hSync;
    logic vSync;
    socPkg::pixT rgb;
    logic topFlag, match0Flag, match1Flag, blankFlag;
    logic topClr, match0Clr, match1Clr, blankClr;

    integer seed;
    int errors;
    int checks;
    socPkg::byteT dmemModel [0:2047];
    logic [10:0] dmemAddrs [$];                     // Addresses holding known data
    socPkg::byteT vramModel [0:`H_ACTIVE * `V_ACTIVE - 1];

    socTop u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic expectEqual(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("** Error at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    //**********************************************************
    // Bus master with one access per cycle
    //**********************************************************
    task automatic busWrite(input socPkg::addrT a, input socPkg::byteT d);
        addr = a;
        wData = d;
        wrEn = 1'b1;
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic checkRead(input string what, input socPkg::addrT a, input int exp);
        addr = a;
        rdEn = 1'b1;
        @(negedge clk);                             // Data follows one cycle later
        rdEn = 1'b0;
        expectEqual(what, rData, exp);
    endtask

    task automatic dmemTraffic();
        logic [10:0] a;
        socPkg::byteT d;
        for (int i = 0; i < 300; i++) begin
            if (dmemAddrs.size() == 0 || rnd(2) == 0) begin
                a = 11'(rnd(2048));
                d = 8'(rnd(256));
                dmemModel[a] = d;
                dmemAddrs.push_back(a);
                busWrite(16'(`DMEM_LO + a), d);
            end else begin
                a = dmemAddrs[rnd(dmemAddrs.size())];
                checkRead("data RAM read", 16'(`DMEM_LO + a), dmemModel[a]);
            end
        end
    endtask

    // Unmapped holes between and above the regions
    task automatic gapReads();
        socPkg::addrT a;
        for (int i = 0; i < 40; i++) begin
            case (rnd(3))
                0: a = 16'(16'h0800 + rnd(16'h0800));
                1: a = 16'(16'h1100 + rnd(16'h0F00));
                default: a = 16'(16'h2961 + rnd(16'hD69F));
            endcase
            checkRead("unmapped read", a, 0);
        end
    endtask

    task automatic ioRegs();
        socPkg::byteT d;
        d = 8'(rnd(256));
        busWrite(16'(`IO_LO + `IO_PINS), d);
        expectEqual("ioPins", ioPins, d);
        checkRead("PINS read", 16'(`IO_LO + `IO_PINS), d);
        for (int r = `IO_TOP; r <= `IO_MATCH1; r++) begin    // TOP, MATCH0, MATCH1
            d = 8'(rnd(256));
            busWrite(16'(`IO_LO + r), d);
            checkRead("timer register read", 16'(`IO_LO + r), d);
        end
    endtask

    //**********************************************************
    // Timer against a cycle model
    //**********************************************************
    task automatic timerRun();
        int top, m0, m1, mCount;
        logic mTop, mM0, mM1, evTop, evM0, evM1;
        top = 16 + rnd(32);
        m0 = rnd(top + 1);
        m1 = rnd(top + 1);
        busWrite(16'(`IO_LO + `IO_TOP), 8'(top));
        busWrite(16'(`IO_LO + `IO_MATCH0), 8'(m0));
        busWrite(16'(`IO_LO + `IO_MATCH1), 8'(m1));
        busWrite(16'(`IO_LO + `IO_CTRL), 8'h01);    // Count starts from 0
        mCount = 0;
        {mTop, mM0, mM1} = 3'b000;
        for (int i = 0; i < 4 * (top + 1); i++) begin
            expectEqual("topFlag", topFlag, mTop);
            expectEqual("match0Flag", match0Flag, mM0);
            expectEqual("match1Flag", match1Flag, mM1);
            topClr = mTop && rnd(4) == 0;
            match0Clr = mM0 && rnd(4) == 0;
            match1Clr = mM1 && rnd(4) == 0;
            evTop = (mCount == top);
            evM0 = (mCount == m0);
            evM1 = (mCount == m1);
            mTop = evTop | (mTop & ~topClr);       // Set beats clear
            mM0 = evM0 | (mM0 & ~match0Clr);
            mM1 = evM1 | (mM1 & ~match1Clr);
            mCount = evTop ? 0 : mCount + 1;
            @(negedge clk);
        end
        {topClr, match0Clr, match1Clr} = 3'b000;
        // Timer still steps once at the edge that stops it
        evTop = (mCount == top);
        mTop = mTop | evTop;
        mM0 = mM0 | (mCount == m0);
        mM1 = mM1 | (mCount == m1);
        mCount = evTop ? 0 : mCount + 1;
        busWrite(16'(`IO_LO + `IO_CTRL), 8'h00);
        checkRead("FLAGS read", 16'(`IO_LO + `IO_FLAGS), {mM1, mM0, mTop});
        checkRead("COUNT read", 16'(`IO_LO + `IO_COUNT), mCount);   // Held while stopped
    endtask

    task automatic videoRam();
        for (int i = 0; i < `H_ACTIVE * `V_ACTIVE; i++) begin
            vramModel[i] = 8'(rnd(256));
            busWrite(16'(`VMEM_LO + i), vramModel[i]);
        end
        for (int i = 0; i < `H_ACTIVE * `V_ACTIVE; i++) begin
            checkRead("video RAM read", 16'(`VMEM_LO + i), vramModel[i]);
        end
        busWrite(`VMEM_HI, 8'h5A);                  // Last mapped byte
        checkRead("video RAM top read", `VMEM_HI, 8'h5A);
    endtask

    //**********************************************************
    // Raster and blanking flag over two frames
    //**********************************************************
    task automatic rasterFrames();
        int p, h, v, rises, waitCount, expRgb;
        logic prevV, prevBlank, mBlank, found;
        blankClr = 1'b1;                            // Hold flag low while searching
        found = 1'b0;
        prevV = vSync;
        for (waitCount = 0; waitCount < 2 * FRAME && !found; waitCount++) begin
            @(negedge clk);
            found = prevV && !vSync;
            prevV = vSync;
        end
        if (!found) begin
            errors++;
            $display("Timed out waiting for a falling edge of vSync");
            blankClr = 1'b0;
            return;
        end
        p = (`V_ACTIVE + `V_FRONT) * `H_TOTAL;      // Sync fall shows column 0 of the first sync line
        mBlank = 1'b0;
        prevBlank = 1'b0;
        rises = 0;
        for (int n = 0; n < 2 * FRAME; n++) begin
            v = p / `H_TOTAL;
            h = p % `H_TOTAL;
            expRgb = (h < `H_ACTIVE && v < `V_ACTIVE) ? vramModel[v * `H_ACTIVE + h][2:0] : 0;
            expectEqual("rgb", rgb, expRgb);
            expectEqual("hSync", hSync, !(h >= `H_ACTIVE + `H_FRONT &&
                                          h < `H_ACTIVE + `H_FRONT + `H_SYNC));
            expectEqual("vSync", vSync, !(v >= `V_ACTIVE + `V_FRONT &&
                                          v < `V_ACTIVE + `V_FRONT + `V_SYNC));
            expectEqual("blankFlag", blankFlag, mBlank);
            rises += (blankFlag && !prevBlank) ? 1 : 0;
            prevBlank = blankFlag;
            blankClr = mBlank && (p == BLANK_VIS + 20);
            p = (p + 1) % FRAME;
            mBlank = (p == BLANK_VIS) | (mBlank & ~blankClr);
            @(negedge clk);
        end
        blankClr = 1'b0;
        expectEqual("blankFlag rises in two frames", rises, 2);
    endtask

    initial begin
        seed = 28;
        errors = 0;
        checks = 0;
        rstN = 1'b0;
        addr = '0;
        wData = '0;
        wrEn = 1'b0;
        rdEn = 1'b0;
        {topClr, match0Clr, match1Clr, blankClr} = 4'b0000;
        repeat (10) @(negedge clk);

        // Reset values
        expectEqual("ioPins after reset", ioPins, 0);
        expectEqual("flags after reset", {topFlag, match0Flag, match1Flag, blankFlag}, 0);
        expectEqual("syncs after reset", {hSync, vSync}, 2'b11);
        expectEqual("rgb after reset", rgb, 0);
        rstN = 1'b1;
        @(negedge clk);

        dmemTraffic();
        gapReads();
        ioRegs();
        timerRun();
        videoRam();
        rasterFrames();

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/socTop.sv
`default_nettype none

module socTop (
    input  wire                clk,
    input  wire                rstN,
    input  wire socPkg::addrT  addr,
    input  wire socPkg::byteT  wData,
    input  wire                wrEn,
    input  wire                rdEn,
    output socPkg::byteT       rData,
    output socPkg::byteT       ioPins,
    output logic               hSync,
    output logic               vSync,
    output socPkg::pixT        rgb,
    output logic               topFlag,
    output logic               match0Flag,
    output logic               match1Flag,
    output logic               blankFlag,
    input  wire                topClr,
    input  wire                match0Clr,
    input  wire                match1Clr,
    input  wire                blankClr
);

    logic dmemWrEn;
    logic dmemRdEn;
    logic ioWrEn;
    logic ioRdEn;
    logic vmemWrEn;
    logic vmemRdEn;
    socPkg::byteT dmemRData;
    socPkg::byteT ioRData;
    socPkg::byteT vmemRData;

    //**********************************************************
    // Memory map
    //**********************************************************
    addrDecode decoder (
        .clk(clk), .rstN(rstN), .addr(addr), .wrEn(wrEn), .rdEn(rdEn),
        .dmemRData(dmemRData), .ioRData(ioRData), .vmemRData(vmemRData),
        .dmemWrEn(dmemWrEn), .dmemRdEn(dmemRdEn),
        .ioWrEn(ioWrEn), .ioRdEn(ioRdEn),
        .vmemWrEn(vmemWrEn), .vmemRdEn(vmemRdEn),
        .rData(rData)
    );

    //**********************************************************
    // Data memory
    //**********************************************************
    dataRam dataMemory (
        .clk(clk), .addr(addr[10:0]), .wData(wData),
        .wrEn(dmemWrEn), .rdEn(dmemRdEn), .rData(dmemRData)
    );

    //**********************************************************
    // Pins and timer
    //**********************************************************
    ioBlock io (
        .clk(clk), .rstN(rstN), .addr(addr[7:0]), .wData(wData),
        .wrEn(ioWrEn), .rdEn(ioRdEn), .rData(ioRData), .ioPins(ioPins),
        .topFlag(topFlag), .match0Flag(match0Flag), .match1Flag(match1Flag),
        .topClr(topClr), .match0Clr(match0Clr), .match1Clr(match1Clr)
    );

    //**********************************************************
    // Video
    //**********************************************************
    videoUnit video (
        .clk(clk), .rstN(rstN), .addr(addr[11:0]), .wData(wData),
        .wrEn(vmemWrEn), .rdEn(vmemRdEn), .rData(vmemRData),
        .hSync(hSync), .vSync(vSync), .rgb(rgb),
        .blankFlag(blankFlag), .blankClr(blankClr)
    );

endmodule

`default_nettype wire

//--- src/videoUnit.sv
`default_nettype none

`include "soc_defs.svh"

module videoUnit (
    input  wire                clk,
    input  wire                rstN,
    input  wire [11:0]         addr,
    input  wire socPkg::byteT  wData,
    input  wire                wrEn,
    input  wire                rdEn,
    output socPkg::byteT       rData,
    output logic               hSync,
    output logic               vSync,
    output socPkg::pixT        rgb,
    output logic               blankFlag,
    input  wire                blankClr
);

    // Video RAM covers the whole mapped window
    socPkg::byteT vmem [0:`VMEM_HI - `VMEM_LO];

    logic [$clog2(`H_TOTAL)-1:0] hCount;        // Column within line
    logic [$clog2(`V_TOTAL)-1:0] vCount;        // Line within frame
    logic [11:0] pixAddr;

    logic active;
    logic hSyncRaw;
    logic vSyncRaw;
    logic blankEvt;

    // First delay stage
    socPkg::pixT pixQ;
    logic activeD1;
    logic hSyncD1;
    logic vSyncD1;

    //**********************************************************
    // Bus port
    //**********************************************************
    always_ff @(posedge clk) begin
        if (wrEn) begin
            vmem[addr] <= wData;
        end
    end

    always_ff @(posedge clk) begin
        if (rdEn) begin
            rData <= vmem[addr];
        end
    end

    //**********************************************************
    // Raster counters
    //**********************************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hCount <= '0;
            vCount <= '0;
        end else if (hCount == `H_TOTAL - 1) begin
            hCount <= '0;
            vCount <= (vCount == `V_TOTAL - 1) ? '0 : vCount + 1'b1;
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    assign active   = (hCount < `H_ACTIVE) && (vCount < `V_ACTIVE);
    assign hSyncRaw = !((hCount >= `H_ACTIVE + `H_FRONT) &&
                        (hCount < `H_ACTIVE + `H_FRONT + `H_SYNC));     // Active low
    assign vSyncRaw = !((vCount >= `V_ACTIVE + `V_FRONT) &&
                        (vCount < `V_ACTIVE + `V_FRONT + `V_SYNC));
    assign pixAddr  = 12'(vCount) * 12'(`H_ACTIVE) + 12'(hCount);     // Row x 16 + column
    assign blankEvt = (vCount == `V_ACTIVE) && (hCount == 0);

    // Pixel fetch from the raster port
    always_ff @(posedge clk) begin
        pixQ <= vmem[pixAddr][2:0];
    end

    //**********************************************************
    // Two stage output delay
    //**********************************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            activeD1 <= 1'b0;
            hSyncD1  <= 1'b1;
            vSyncD1  <= 1'b1;
            hSync    <= 1'b1;
            vSync    <= 1'b1;
            rgb      <= '0;
        end else begin
            activeD1 <= active;
            hSyncD1  <= hSyncRaw;
            vSyncD1  <= vSyncRaw;
            hSync    <= hSyncD1;
            vSync    <= vSyncD1;
            rgb      <= activeD1 ? pixQ : '0;       // Black in blanking
        end
    end

    // Blanking start flag, set wins over clear
    always_ff @(posedge clk) begin
        if (!rstN) blankFlag <= 1'b0;
        else blankFlag <= blankEvt | (blankFlag & ~blankClr);
    end

    // Sync pulses only fall inside blanking
    assert property (@(posedge clk) disable iff (!rstN) !hSync |-> rgb == '0);

endmodule

`default_nettype wire

//--- src/ioBlock.sv
`default_nettype none

`include "soc_defs.svh"

module ioBlock (
    input  wire                clk,
    input  wire                rstN,
    input  wire [7:0]          addr,
    input  wire socPkg::byteT  wData,
    input  wire                wrEn,
    input  wire                rdEn,
    output socPkg::byteT       rData,
    output socPkg::byteT       ioPins,
    output logic               topFlag,
    output logic               match0Flag,
    output logic               match1Flag,
    input  wire                topClr,
    input  wire                match0Clr,
    input  wire                match1Clr
);

    socPkg::byteT ctrlQ;
    socPkg::byteT topQ;
    socPkg::byteT match0Q;
    socPkg::byteT match1Q;
    socPkg::byteT countQ;

    logic running;
    logic topEvt;
    logic match0Evt;
    logic match1Evt;

    //**********************************************************
    // Register writes
    //**********************************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ioPins  <= '0;
            ctrlQ   <= '0;              // Timer stopped
            topQ    <= '0;
            match0Q <= '0;
            match1Q <= '0;
        end else if (wrEn) begin
            case (addr)
                `IO_PINS:   ioPins  <= wData;
                `IO_CTRL:   ctrlQ   <= wData;
                `IO_TOP:    topQ    <= wData;
                `IO_MATCH0: match0Q <= wData;
                `IO_MATCH1: match1Q <= wData;
                default: ;                  // FLAGS and COUNT are read only
            endcase
        end
    end

    //**********************************************************
    // Timer
    //**********************************************************
    assign running   = ctrlQ[0];
    assign topEvt    = running && (countQ == topQ);
    assign match0Evt = running && (countQ == match0Q);
    assign match1Evt = running && (countQ == match1Q);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            countQ <= '0;
        end else if (running) begin
            countQ <= topEvt ? '0 : countQ + 1'b1;      // Wrap at TOP
        end
    end

    // Sticky flags, set wins over clear
    always_ff @(posedge clk) begin
        if (!rstN) begin
            topFlag    <= 1'b0;
            match0Flag <= 1'b0;
            match1Flag <= 1'b0;
        end else begin
            topFlag    <= topEvt | (topFlag & ~topClr);
            match0Flag <= match0Evt | (match0Flag & ~match0Clr);
            match1Flag <= match1Evt | (match1Flag & ~match1Clr);
        end
    end

    // Readback
    always_ff @(posedge clk) begin
        if (rdEn) begin
            case (addr)
                `IO_PINS:   rData <= ioPins;
                `IO_CTRL:   rData <= ctrlQ;
                `IO_TOP:    rData <= topQ;
                `IO_MATCH0: rData <= match0Q;
                `IO_MATCH1: rData <= match1Q;
                `IO_FLAGS:  rData <= {5'b0, match1Flag, match0Flag, topFlag};
                `IO_COUNT:  rData <= countQ;
                default:    rData <= '0;
            endcase
        end
    end

    // A clear without a fresh event leaves the flag low next cycle
    property clrTakes(logic clr, logic evt, logic flag);
        @(posedge clk) disable iff (!rstN) clr && !evt |=> !flag;
    endproperty

    assert property (clrTakes(topClr, topEvt, topFlag));
    assert property (clrTakes(match0Clr, match0Evt, match0Flag));
    assert property (clrTakes(match1Clr, match1Evt, match1Flag));

endmodule

`default_nettype wire

//--- src/dataRam.sv
`default_nettype none

`include "soc_defs.svh"

module dataRam (
    input  wire                clk,
    input  wire [10:0]         addr,
    input  wire socPkg::byteT  wData,
    input  wire                wrEn,
    input  wire                rdEn,
    output socPkg::byteT       rData
);

    // 2 KiB of byte storage
    socPkg::byteT mem [0:`DMEM_HI - `DMEM_LO];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[addr] <= wData;
        end
    end

    // Registered read, holds between reads
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rData <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- src/addrDecode.sv
`default_nettype none

`include "soc_defs.svh"

module addrDecode (
    input  wire socPkg::addrT  addr,
    input  wire                clk,
    input  wire                rstN,
    input  wire                wrEn,
    input  wire                rdEn,
    input  wire socPkg::byteT  dmemRData,
    input  wire socPkg::byteT  ioRData,
    input  wire socPkg::byteT  vmemRData,
    output logic               dmemWrEn,
    output logic               dmemRdEn,
    output logic               ioWrEn,
    output logic               ioRdEn,
    output logic               vmemWrEn,
    output logic               vmemRdEn,
    output socPkg::byteT       rData
);

    localparam socPkg::regionT REGION_DMEM = 2'd0;
    localparam socPkg::regionT REGION_IO   = 2'd1;
    localparam socPkg::regionT REGION_VMEM = 2'd2;
    localparam socPkg::regionT REGION_NONE = 2'd3;

    logic inDmem;
    logic inIo;
    logic inVmem;
    socPkg::regionT regionD;
    socPkg::regionT regionQ;        // Region of the last read

    function automatic logic inRange(socPkg::addrT a, socPkg::addrT lo, socPkg::addrT hi);
        return (a >= lo) && (a <= hi);
    endfunction

    //**********************************************************
    // Range decode
    //**********************************************************
    always_comb begin
        inDmem = inRange(addr, `DMEM_LO, `DMEM_HI);
        inIo   = inRange(addr, `IO_LO, `IO_HI);
        inVmem = inRange(addr, `VMEM_LO, `VMEM_HI);
        if (inDmem) regionD = REGION_DMEM;
        else if (inIo) regionD = REGION_IO;
        else if (inVmem) regionD = REGION_VMEM;
        else regionD = REGION_NONE;
    end

    assign dmemWrEn = wrEn & inDmem;
    assign dmemRdEn = rdEn & inDmem;
    assign ioWrEn   = wrEn & inIo;
    assign ioRdEn   = rdEn & inIo;
    assign vmemWrEn = wrEn & inVmem;
    assign vmemRdEn = rdEn & inVmem;

    // Region follows the read so rData lines up with the peripheral's registered output
    always_ff @(posedge clk) begin
        if (!rstN) regionQ <= REGION_NONE;
        else if (rdEn) regionQ <= regionD;
    end

    always_comb begin
        case (regionQ)
            REGION_DMEM: rData = dmemRData;
            REGION_IO:   rData = ioRData;
            REGION_VMEM: rData = vmemRData;
            default:     rData = '0;        // Unmapped reads return 0
        endcase
    end

    // Only one peripheral may see an access per cycle
    assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({dmemWrEn, dmemRdEn, ioWrEn, ioRdEn, vmemWrEn, vmemRdEn}));

endmodule

`default_nettype wire

//--- src/socPkg.sv
`default_nettype none

// Vector types shared across the SoC core and its testbench
package socPkg;

    // Bus address as seen on the external data port
    typedef logic [15:0] addrT;

    // Data byte on the bus and inside every memory
    typedef logic [7:0] byteT;

    // Read region code
    // 0 data RAM, 1 I/O, 2 video, 3 unmapped
    typedef logic [1:0] regionT;

    // One pixel as R, G, B bits
    typedef logic [2:0] pixT;

endpackage

`default_nettype wire

//--- src/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

//**********************************************************
// Memory map
//**********************************************************
`define DMEM_LO     16'h0000
`define DMEM_HI     16'h07FF
`define IO_LO       16'h1000
`define IO_HI       16'h10FF
`define VMEM_LO     16'h2000
`define VMEM_HI     16'h2960

//**********************************************************
// I/O register offsets
//**********************************************************
`define IO_PINS     8'h00
`define IO_CTRL     8'h01
`define IO_TOP      8'h02
`define IO_MATCH0   8'h03
`define IO_MATCH1   8'h04
`define IO_FLAGS    8'h05       // Read only
`define IO_COUNT    8'h06       // Read only, live count

//**********************************************************
// Raster timing in clocks and lines
//**********************************************************
`define H_ACTIVE    16
`define H_FRONT     2
`define H_SYNC      4
`define H_BACK      2
`define H_TOTAL     (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_ACTIVE    12
`define V_FRONT     1
`define V_SYNC      2
`define V_BACK      1
`define V_TOTAL     (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`endif
